// ==== verilog/bridge_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared definitions for the AHB-Lite to external bus bridge
// Bus widths, lane geometry, AHB encodings, transfer state type
// Packed structs for the captured address phase, the external
// request and its completion
//////////////////////////////////////////////////////////////////////

package bridge_pkg;

    // AHB side widths
    localparam int AHB_ADDR_W = 32;
    localparam int AHB_DATA_W = 32;

    // External side is one 32-bit word with four byte lanes
    localparam int EXT_DATA_W = 32;
    localparam int EXT_BYTES  = EXT_DATA_W / 8;
    localparam int LANE_BITS  = 2;

    // HTRANS values that start a transfer
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    // Only OKAY is ever returned
    localparam logic [1:0] HRESP_OKAY = 2'b00;

    // HSIZE as seen on the bus
    // Bits 1:0 give the size, bit 2 is not used by this bridge
    typedef logic [2:0] hsize_t;

    // Transfer state of the slave port
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        ADDR     = 2'd1,
        WAIT_ACK = 2'd2,
        RESP     = 2'd3
    } bridge_state_t;

    // Address phase captured at acceptance
    typedef struct packed {
        logic [AHB_ADDR_W-1:0] addr;
        logic                  write;
        hsize_t                size;
    } xfer_ctrl_t;

    // One request as it goes out on the external bus
    // word_addr has the lane bits already dropped
    typedef struct packed {
        logic [AHB_ADDR_W-LANE_BITS-1:0] word_addr;
        logic                            write;
        logic [EXT_BYTES-1:0]            byteenable;
        logic [EXT_DATA_W-1:0]           wdata;
    } ext_cmd_t;

    // Completion of the outstanding request
    // rdata is raw, still on its original lanes
    typedef struct packed {
        logic                  done;
        logic [EXT_DATA_W-1:0] rdata;
    } ext_rsp_t;

endpackage

// ==== verilog/ahb_slave_port.sv ====
//////////////////////////////////////////////////////////////////////
// AHB-Lite slave port of the bridge
// Four-state transfer FSM, address phase capture, data phase
// write data hand-off, registered hreadyout and hrdata
//////////////////////////////////////////////////////////////////////

module ahb_slave_port (
    input  logic                                clk,
    input  logic                                rst_n,
    // AHB-Lite slave pins
    input  logic                                hsel,
    input  logic [1:0]                          htrans,
    input  logic                                hwrite,
    input  logic [bridge_pkg::AHB_ADDR_W-1:0]   haddr,
    input  bridge_pkg::hsize_t                  hsize,
    input  logic [bridge_pkg::AHB_DATA_W-1:0]   hwdata,
    // Completion from the external side and its aligned read word
    input  bridge_pkg::ext_rsp_t                rsp,
    input  logic [bridge_pkg::AHB_DATA_W-1:0]   aligned_rdata,
    output logic                                hreadyout,
    output logic [bridge_pkg::AHB_DATA_W-1:0]   hrdata,
    // Towards the lane aligner and the external master
    output bridge_pkg::xfer_ctrl_t              ctrl,
    output logic [bridge_pkg::AHB_DATA_W-1:0]   wdata,
    output logic                                issue
);

    bridge_pkg::bridge_state_t state;
    bridge_pkg::bridge_state_t state_nxt;
    logic                      trans_valid;
    logic                      accept;

    // NONSEQ and SEQ both start a transfer, IDLE and BUSY are ignored
    assign trans_valid = (htrans == bridge_pkg::HTRANS_NONSEQ) ||
                         (htrans == bridge_pkg::HTRANS_SEQ);

    // Address phase is taken only while the bus sees us ready
    // That is IDLE, or RESP for a back-to-back transfer
    assign accept = hsel && trans_valid && hreadyout &&
                    ((state == bridge_pkg::IDLE) || (state == bridge_pkg::RESP));

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            bridge_pkg::IDLE: begin
                if (accept) begin
                    state_nxt = bridge_pkg::ADDR;
                end
            end
            bridge_pkg::ADDR: begin
                // Single cycle, request gets registered at its end
                state_nxt = bridge_pkg::WAIT_ACK;
            end
            bridge_pkg::WAIT_ACK: begin
                if (rsp.done) begin
                    state_nxt = bridge_pkg::RESP;
                end
            end
            bridge_pkg::RESP: begin
                state_nxt = accept ? bridge_pkg::ADDR : bridge_pkg::IDLE;
            end
            default: begin
                state_nxt = bridge_pkg::IDLE;
            end
        endcase
    end

    // State, hreadyout and read data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= bridge_pkg::IDLE;
            hreadyout <= 1'b1;
            hrdata    <= '0;
        end else begin
            state <= state_nxt;
            // Ready whenever the next cycle can take an address phase
            hreadyout <= (state_nxt == bridge_pkg::IDLE) ||
                         (state_nxt == bridge_pkg::RESP);
            // Read word lands together with the move to RESP
            if (rsp.done && !ctrl.write) begin
                hrdata <= aligned_rdata;
            end
        end
    end

    // Address phase capture
    always_ff @(posedge clk) begin
        if (accept) begin
            ctrl.addr  <= haddr;
            ctrl.write <= hwrite;
            ctrl.size  <= hsize;
        end
    end

    // ADDR is the first data phase cycle, hwdata is live here
    assign issue = (state == bridge_pkg::ADDR);
    // Idle lanes stay quiet outside ADDR
    assign wdata = issue ? hwdata : '0;

    // Wait states cover the whole request, never ready while issuing
    a_issue_not_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue |-> !hreadyout
    ) else $error("issue raised with hreadyout high");

    // A completion can only belong to the transfer in WAIT_ACK
    a_done_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp.done |-> (state == bridge_pkg::WAIT_ACK)
    ) else $error("rsp.done outside WAIT_ACK");

endmodule

// ==== verilog/byte_lane_align.sv ====
//////////////////////////////////////////////////////////////////////
// Byte-lane aligner between the AHB port and the external bus
// Word address and byte enables, write data shift onto the lanes,
// read data shift down to lane 0 and mask to the access size
//////////////////////////////////////////////////////////////////////

module byte_lane_align (
    input  bridge_pkg::xfer_ctrl_t              ctrl,
    input  logic [bridge_pkg::AHB_DATA_W-1:0]   wdata,
    input  logic [bridge_pkg::EXT_DATA_W-1:0]   ext_rdata,
    output bridge_pkg::ext_cmd_t                cmd,
    output logic [bridge_pkg::AHB_DATA_W-1:0]   aligned_rdata
);

    // Lane offset inside the word and the same offset in bits
    logic [bridge_pkg::LANE_BITS-1:0]   offset;
    logic [bridge_pkg::LANE_BITS+2:0]   shift_bits;
    // Access size in bytes, 1, 2 or 4
    logic [bridge_pkg::LANE_BITS:0]     nbytes;
    logic [bridge_pkg::EXT_BYTES-1:0]   byteenable;
    logic [bridge_pkg::AHB_DATA_W-1:0]  read_mask;

    assign offset     = ctrl.addr[bridge_pkg::LANE_BITS-1:0];
    assign shift_bits = {offset, 3'b000};

    // Size decode, bit 2 of hsize plays no part
    always_comb begin
        case (ctrl.size[1:0])
            2'd0: begin
                nbytes    = (bridge_pkg::LANE_BITS + 1)'(1);
                read_mask = bridge_pkg::AHB_DATA_W'(8'hff);
            end
            2'd1: begin
                nbytes    = (bridge_pkg::LANE_BITS + 1)'(2);
                read_mask = bridge_pkg::AHB_DATA_W'(16'hffff);
            end
            default: begin
                // Word, and anything wider treated as a word
                nbytes    = (bridge_pkg::LANE_BITS + 1)'(4);
                read_mask = '1;
            end
        endcase
    end

    // Enable lanes offset .. offset+nbytes-1
    // Lanes past the top of the word simply never match
    always_comb begin
        byteenable = '0;
        for (int i = 0; i < bridge_pkg::EXT_BYTES; i++) begin
            if ((i >= int'(offset)) && (i < int'(offset) + int'(nbytes))) begin
                byteenable[i] = 1'b1;
            end
        end
    end

    // Forward path, one external request
    always_comb begin
        cmd.word_addr  = ctrl.addr[bridge_pkg::AHB_ADDR_W-1:bridge_pkg::LANE_BITS];
        cmd.write      = ctrl.write;
        cmd.byteenable = byteenable;
        // AHB master puts narrow data on lane 0
        cmd.wdata      = wdata << shift_bits;
    end

    // Return path, addressed bytes down to lane 0, upper bits cleared
    assign aligned_rdata = (ext_rdata >> shift_bits) & read_mask;

endmodule

// ==== verilog/ext_bus_master.sv ====
//////////////////////////////////////////////////////////////////////
// External bus master side of the bridge
// Registers one request on issue and holds it until ext_ack,
// reports completion combinationally
//////////////////////////////////////////////////////////////////////

module ext_bus_master #(
    parameter int EXT_ADDR_W = 30
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    // Request from the slave port and lane aligner
    input  logic                                  issue,
    input  bridge_pkg::ext_cmd_t                  cmd,
    // External bus pins
    input  logic [bridge_pkg::EXT_DATA_W-1:0]     ext_rdata,
    input  logic                                  ext_ack,
    output logic [EXT_ADDR_W-1:0]                 ext_addr,
    output logic                                  ext_read,
    output logic                                  ext_write,
    output logic [bridge_pkg::EXT_DATA_W-1:0]     ext_wdata,
    output logic [bridge_pkg::EXT_BYTES-1:0]      ext_byteenable,
    // Completion back to the slave port
    output bridge_pkg::ext_rsp_t                  rsp
);

    // Word address must fit the AHB word address
    if ((EXT_ADDR_W < 8) || (EXT_ADDR_W > bridge_pkg::AHB_ADDR_W - bridge_pkg::LANE_BITS))
    begin : g_addr_w_check
        $error("EXT_ADDR_W out of range");
    end

    logic pending;
    logic done;

    // A request is up while either strobe is high
    assign pending = ext_read | ext_write;
    // ack without a request means nothing
    assign done    = pending & ext_ack;

    // Strobes and enables
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ext_read       <= 1'b0;
            ext_write      <= 1'b0;
            ext_byteenable <= '0;
        end else if (issue) begin
            ext_read       <= !cmd.write;
            ext_write      <= cmd.write;
            ext_byteenable <= cmd.byteenable;
        end else if (done) begin
            // Everything drops at the ack edge
            ext_read       <= 1'b0;
            ext_write      <= 1'b0;
            ext_byteenable <= '0;
        end
    end

    // Address and write data, held until the next issue
    always_ff @(posedge clk) begin
        if (issue) begin
            // Upper word address bits fall off for narrow external buses
            ext_addr  <= cmd.word_addr[EXT_ADDR_W-1:0];
            ext_wdata <= cmd.wdata;
        end
    end

    // Raw read data, lane extraction happens in the aligner
    assign rsp = '{done: done, rdata: ext_rdata};

    // Strobes are mutually exclusive
    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ext_read && ext_write)
    ) else $error("ext_read and ext_write high together");

    // One outstanding request, slave port waits for completion
    a_no_issue_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue |-> !pending
    ) else $error("issue while a request is outstanding");

endmodule

// ==== verilog/ahb_ext_bridge.sv ====
//////////////////////////////////////////////////////////////////////
// AHB-Lite slave to external request/acknowledge bus bridge, top
// Wires the AHB slave port, byte-lane aligner and external master
//////////////////////////////////////////////////////////////////////

module ahb_ext_bridge #(
    parameter int EXT_ADDR_W = 30
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    // AHB-Lite slave
    input  logic                                  hsel,
    input  logic [1:0]                            htrans,
    input  logic                                  hwrite,
    input  logic [bridge_pkg::AHB_ADDR_W-1:0]     haddr,
    input  bridge_pkg::hsize_t                    hsize,
    input  logic [bridge_pkg::AHB_DATA_W-1:0]     hwdata,
    output logic [bridge_pkg::AHB_DATA_W-1:0]     hrdata,
    output logic                                  hreadyout,
    output logic [1:0]                            hresp,
    // External bus
    output logic [EXT_ADDR_W-1:0]                 ext_addr,
    output logic                                  ext_read,
    output logic                                  ext_write,
    output logic [bridge_pkg::EXT_DATA_W-1:0]     ext_wdata,
    output logic [bridge_pkg::EXT_BYTES-1:0]      ext_byteenable,
    input  logic [bridge_pkg::EXT_DATA_W-1:0]     ext_rdata,
    input  logic                                  ext_ack
);

    bridge_pkg::xfer_ctrl_t             ctrl;
    bridge_pkg::ext_cmd_t               cmd;
    bridge_pkg::ext_rsp_t               rsp;
    logic [bridge_pkg::AHB_DATA_W-1:0]  wdata;
    logic [bridge_pkg::AHB_DATA_W-1:0]  aligned_rdata;
    logic                               issue;

    // No error path
    assign hresp = bridge_pkg::HRESP_OKAY;

    ahb_slave_port u_slave_port (
        .clk           (clk),
        .rst_n         (rst_n),
        .hsel          (hsel),
        .htrans        (htrans),
        .hwrite        (hwrite),
        .haddr         (haddr),
        .hsize         (hsize),
        .hwdata        (hwdata),
        .rsp           (rsp),
        .aligned_rdata (aligned_rdata),
        .hreadyout     (hreadyout),
        .hrdata        (hrdata),
        .ctrl          (ctrl),
        .wdata         (wdata),
        .issue         (issue)
    );

    byte_lane_align u_lane_align (
        .ctrl          (ctrl),
        .wdata         (wdata),
        .ext_rdata     (rsp.rdata),
        .cmd           (cmd),
        .aligned_rdata (aligned_rdata)
    );

    ext_bus_master #(
        .EXT_ADDR_W (EXT_ADDR_W)
    ) u_ext_master (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue          (issue),
        .cmd            (cmd),
        .ext_rdata      (ext_rdata),
        .ext_ack        (ext_ack),
        .ext_addr       (ext_addr),
        .ext_read       (ext_read),
        .ext_write      (ext_write),
        .ext_wdata      (ext_wdata),
        .ext_byteenable (ext_byteenable),
        .rsp            (rsp)
    );

endmodule

// ==== bench/tb_ahb_ext_bridge.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the AHB-Lite to external bus bridge
// Clock and reset, file-driven AHB master, external memory
// responder with random ack delay, checks and watchdog
//////////////////////////////////////////////////////////////////////

module tb_ahb_ext_bridge;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_TESTS = 64;

    // One line of the test file
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [2:0]  size;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        b2b;
    } test_t;

    logic                clk;
    logic                rst_n;
    logic                hsel;
    logic [1:0]          htrans;
    logic                hwrite;
    logic [31:0]         haddr;
    bridge_pkg::hsize_t  hsize;
    logic [31:0]         hwdata;
    logic [31:0]         hrdata;
    logic                hreadyout;
    logic [1:0]          hresp;
    logic [29:0]         ext_addr;
    logic                ext_read;
    logic                ext_write;
    logic [31:0]         ext_wdata;
    logic [3:0]          ext_byteenable;
    logic [31:0]         ext_rdata;
    logic                ext_ack;

    test_t       tests [MAX_TESTS];
    test_t       pending_q [$];
    int          n_tests;
    logic        tests_loaded = 1'b0;
    int          value_errors = 0;
    int          other_errors = 0;
    integer      seed = 32'hc99afe2a;
    logic [31:0] mem [64];

    ahb_ext_bridge u_ahb_ext_bridge (
        .clk            (clk),
        .rst_n          (rst_n),
        .hsel           (hsel),
        .htrans         (htrans),
        .hwrite         (hwrite),
        .haddr          (haddr),
        .hsize          (hsize),
        .hwdata         (hwdata),
        .hrdata         (hrdata),
        .hreadyout      (hreadyout),
        .hresp          (hresp),
        .ext_addr       (ext_addr),
        .ext_read       (ext_read),
        .ext_write      (ext_write),
        .ext_wdata      (ext_wdata),
        .ext_byteenable (ext_byteenable),
        .ext_rdata      (ext_rdata),
        .ext_ack        (ext_ack)
    );

    always #5 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Error at %0d ns: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
        value_errors++;
    endtask

    task automatic report_problem(input string what);
        $display("At %0d ns: %s", $time, what);
        other_errors++;
    endtask

    // Run of 1, 2 or 4 enables starting at the lane offset, cut at lane 3
    function automatic logic [3:0] lane_mask(input logic [1:0] off, input logic [2:0] size);
        logic [7:0] run;
        run = (8'd1 << (8'd1 << size[1:0])) - 8'd1;
        return 4'(run << off);
    endfunction

    // One AHB transfer, address phase then data phase until hreadyout
    task automatic run_transfer(input test_t t);
        while (hreadyout !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        hsel   = 1'b1;
        htrans = bridge_pkg::HTRANS_NONSEQ;
        hwrite = t.write;
        haddr  = t.addr;
        hsize  = t.size;
        pending_q.push_back(t);
        @(posedge clk);
        #1;
        // First data phase cycle, write data goes on lane 0
        hsel   = 1'b0;
        htrans = 2'b00;
        hwdata = t.write ? t.wdata : 32'h0;
        if (hreadyout !== 1'b0) begin
            report_problem("hreadyout high in the first data phase cycle");
        end
        @(posedge clk);
        #1;
        while (hreadyout !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        // Response cycle
        if (!t.write && (hrdata !== t.rdata)) begin
            report_mismatch("hrdata", t.rdata, hrdata);
        end
    endtask

    // Check one external request, hold ack off, then complete it
    task automatic serve_request();
        test_t       t;
        logic [3:0]  exp_be;
        logic [31:0] exp_lanes;
        logic [31:0] lane_bits;
        logic [67:0] held;
        int          delay;
        int          idx;
        if (pending_q.size() == 0) begin
            report_problem("external request without an AHB transfer");
        end else begin
            t         = pending_q.pop_front();
            exp_be    = lane_mask(t.addr[1:0], t.size);
            exp_lanes = t.wdata << (t.addr[1:0] * 8);
            lane_bits = {{8{exp_be[3]}}, {8{exp_be[2]}}, {8{exp_be[1]}}, {8{exp_be[0]}}};
            if (ext_write !== t.write) begin
                report_mismatch("ext_write", t.write, ext_write);
            end
            if (ext_addr !== t.addr[31:2]) begin
                report_mismatch("ext_addr", t.addr[31:2], ext_addr);
            end
            if (ext_byteenable !== exp_be) begin
                report_mismatch("ext_byteenable", exp_be, ext_byteenable);
            end
            if (t.write && ((ext_wdata & lane_bits) !== (exp_lanes & lane_bits))) begin
                report_mismatch("ext_wdata", exp_lanes & lane_bits, ext_wdata & lane_bits);
            end
        end
        if (hreadyout !== 1'b0) begin
            report_problem("hreadyout high while the request waits for ext_ack");
        end
        held  = {ext_read, ext_write, ext_addr, ext_byteenable, ext_wdata};
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) begin
            @(posedge clk);
            #1;
            if ({ext_read, ext_write, ext_addr, ext_byteenable, ext_wdata} !== held) begin
                report_problem("external request changed before ext_ack");
            end
            if (hreadyout !== 1'b0) begin
                report_problem("hreadyout high while the request waits for ext_ack");
            end
        end
        idx = ext_addr[5:0];
        if (ext_write) begin
            for (int b = 0; b < 4; b++) begin
                if (ext_byteenable[b]) begin
                    mem[idx][b*8 +: 8] = ext_wdata[b*8 +: 8];
                end
            end
        end else begin
            ext_rdata = mem[idx];
        end
        ext_ack = 1'b1;
        @(posedge clk);
        #1;
        ext_ack   = 1'b0;
        ext_rdata = 32'h0;
        if (ext_read || ext_write) begin
            report_problem("request still up after ext_ack");
        end
    endtask

    // External memory responder, fill depends on the whole word index
    initial begin : responder
        ext_ack   = 1'b0;
        ext_rdata = 32'h0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = {4{i[5:0], 2'b01}};
        end
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && (ext_read || ext_write)) begin
                serve_request();
            end
        end
    end

    // Bus-wide rules, sampled away from the rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (ext_read && ext_write) begin
                report_problem("ext_read and ext_write high together");
            end
            if (hresp !== bridge_pkg::HRESP_OKAY) begin
                report_mismatch("hresp", bridge_pkg::HRESP_OKAY, hresp);
            end
        end
    end

    initial begin : watchdog
        wait (tests_loaded);
        repeat (n_tests * 20 + 200) @(posedge clk);
        $display("Run stopped, transfers did not complete within %0d cycles",
                 n_tests * 20 + 200);
        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        $display("Verification failed");
        $finish;
    end

    initial begin : master
        integer           fd;
        integer           fields;
        logic [8*8-1:0]   tok;
        logic [8*160-1:0] rest;
        logic [31:0]      a;
        logic [31:0]      wd;
        logic [31:0]      ex;
        integer           sz;
        integer           b2b;
        clk     = 1'b0;
        rst_n   = 1'b0;
        hsel    = 1'b0;
        htrans  = 2'b00;
        hwrite  = 1'b0;
        haddr   = 32'h0;
        hsize   = 3'd0;
        hwdata  = 32'h0;
        n_tests = 0;
        fd = $fopen("bench/bridge_tests.txt", "r");
        if (fd == 0) begin
            report_problem("test file bench/bridge_tests.txt could not be opened");
        end else begin
            // Lines starting with # are comments
            while (!$feof(fd) && (n_tests < MAX_TESTS)) begin
                if ($fscanf(fd, "%s", tok) != 1) begin
                    break;
                end
                if (tok == "#") begin
                    fields = $fgets(rest, fd);
                end else begin
                    fields = $fscanf(fd, "%h %d %h %h %d", a, sz, wd, ex, b2b);
                    if ((fields != 5) || ((tok != "W") && (tok != "R"))) begin
                        report_problem("malformed line in the test file");
                        break;
                    end
                    tests[n_tests] = '{write: (tok == "W"), addr: a, size: sz[2:0],
                                       wdata: wd, rdata: ex, b2b: b2b[0]};
                    n_tests++;
                end
            end
            $fclose(fd);
        end
        tests_loaded = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        // Values held by reset
        if (hreadyout !== 1'b1) begin
            report_mismatch("hreadyout", 32'h1, hreadyout);
        end
        if (ext_read !== 1'b0) begin
            report_mismatch("ext_read", 32'h0, ext_read);
        end
        if (ext_write !== 1'b0) begin
            report_mismatch("ext_write", 32'h0, ext_write);
        end
        if (hrdata !== 32'h0) begin
            report_mismatch("hrdata", 32'h0, hrdata);
        end
        rst_n = 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            // Without b2b the response cycle stays idle
            if ((i > 0) && !tests[i].b2b) begin
                @(posedge clk);
                #1;
            end
            run_transfer(tests[i]);
        end
        repeat (2) @(posedge clk);
        if (pending_q.size() != 0) begin
            report_problem("AHB transfers never showed up on the external bus");
        end
        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0) && (n_tests > 0)) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/bridge_pkg.sv
verilog/ahb_slave_port.sv
verilog/byte_lane_align.sv
verilog/ext_bus_master.sv
verilog/ahb_ext_bridge.sv
bench/tb_ahb_ext_bridge.sv

// ==== bench/bridge_tests.txt ====
# op(W/R) addr(hex) size(0 byte,1 half,2 word) wdata(hex, lane 0) rdata(hex) b2b(0/1)
# rdata is the expected hrdata for reads, b2b issues the transfer in the response cycle
# Word 0x10, full word then every byte and halfword back
W 00000010 2 a1b2c3d4 00000000 0
R 00000010 2 00000000 a1b2c3d4 1
R 00000010 0 00000000 000000d4 1
R 00000011 0 00000000 000000c3 0
R 00000012 0 00000000 000000b2 1
R 00000013 0 00000000 000000a1 1
R 00000010 1 00000000 0000c3d4 0
R 00000012 1 00000000 0000a1b2 1
# Word 0x20, byte writes on each lane
W 00000020 2 00000000 00000000 0
W 00000020 0 00000011 00000000 1
W 00000021 0 00000022 00000000 1
W 00000022 0 00000033 00000000 0
W 00000023 0 00000044 00000000 1
R 00000020 2 00000000 44332211 1
# Word 0x30, halfword writes over all ones
W 00000030 2 ffffffff 00000000 0
W 00000030 1 00005a5a 00000000 1
W 00000032 1 0000c33c 00000000 1
R 00000030 2 00000000 c33c5a5a 0
R 00000031 0 00000000 0000005a 1
R 00000033 0 00000000 000000c3 1
R 00000032 1 00000000 0000c33c 0
# Word 0x40, narrow writes with junk above the access size
W 00000040 2 00000000 00000000 1
W 00000041 0 deadbeef 00000000 1
W 00000042 1 cafe1234 00000000 1
R 00000040 2 00000000 1234ef00 1
R 00000041 0 00000000 000000ef 0
R 00000040 1 00000000 0000ef00 1
# Earlier words again, and the top word of the memory
R 00000010 2 00000000 a1b2c3d4 0
W 000000fc 2 89abcdef 00000000 1
R 000000fe 1 00000000 000089ab 1
R 000000fd 0 00000000 000000cd 1
R 00000022 1 00000000 00004433 0
R 00000021 0 00000000 00000022 1
R 000000fc 2 00000000 89abcdef 1
R 00000030 0 00000000 0000005a 0
R 00000043 0 00000000 00000012 1
R 00000020 1 00000000 00002211 1
